// ==== Bender.yml ====
package:
  name: pe_vector

sources:
  - rtl/pe_pkg.sv
  - rtl/pe_stream_if.sv
  - rtl/register_pipe.sv
  - rtl/pe_alu.sv
  - rtl/elem_counter.sv
  - rtl/pe_ctrl.sv
  - rtl/pe_top.sv
  - target: test
    files:
      - tb/tb_pe_top.sv

// ==== project.f ====
rtl/pe_pkg.sv
rtl/pe_stream_if.sv
rtl/register_pipe.sv
rtl/pe_alu.sv
rtl/elem_counter.sv
rtl/pe_ctrl.sv
rtl/pe_top.sv
tb/tb_pe_top.sv

// ==== rtl/elem_counter.sv ====
`timescale 1ns/10ps

// counts accepted elements of the running vector
module elem_counter
    import pe_pkg::*;
(
    input  logic clk,
    input  logic i_rst,
    input  logic i_clear,      // start of a new vector
    input  logic i_count_en,   // element accepted this cycle
    input  len_t i_len,
    output len_t o_count,      // elements accepted so far
    output logic o_last_elem   // this accepted element is number i_len
);

    len_t count_q;
    len_t last_idx;   // zero based index of the final element

    always_ff @(posedge clk) begin
        if (i_rst || i_clear) begin
            count_q <= '0;
        end else if (i_count_en) begin
            count_q <= count_q + len_t'(1);
        end
    end

    // length zero never reaches here, ctrl skips the run
    assign last_idx = i_len - len_t'(1);

    // flags the beat on the same cycle it is accepted
    assign o_last_elem = i_count_en && (count_q == last_idx);

    assign o_count = count_q;

endmodule

// ==== rtl/pe_alu.sv ====
`timescale 1ns/10ps

// integer datapath, every op lands exactly LATENCY cycles after acceptance
// multiply stage LATENCY/2 deep, add stage LATENCY/2 deep
module pe_alu
    import pe_pkg::*;
#(
    parameter int LATENCY = 8
) (
    input  logic        clk,
    input  logic        i_rst,
    pe_stream_if.sink   s_in,    // accepted beat, operand a in data
    input  data_t       i_b,
    input  data_t       i_c,
    pe_stream_if.source m_out    // result beat
);

    localparam int HALF   = LATENCY / 2;
    localparam int OP_W   = $bits(pe_op_e);
    localparam int HALF_W = 2 + OP_W + 3 * DATA_W;   // last, valid, op, c, b, a
    localparam int FULL_W = 2 + OP_W + DATA_W;       // last, valid, op, a

    // multiply stage
    data_t prod;      // a * b, low half
    data_t mul_h;     // product at half latency
    data_t mul_f;     // product at full latency, for MUL

    // operands and side band at half latency
    data_t            a_h;
    data_t            b_h;
    data_t            c_h;
    logic             valid_h;
    logic             last_h;
    logic [OP_W-1:0]  op_h_raw;
    pe_op_e           op_h;

    // side band at full latency
    data_t            a_f;
    logic             valid_f;
    logic             last_f;
    logic [OP_W-1:0]  op_f_raw;
    pe_op_e           op_f;

    // add stage
    data_t add_in;
    data_t sum_f;

    // truncating to data_t keeps the low half, same for signed and unsigned
    assign prod = s_in.data * i_b;

    // product goes through the multiply stage registers
    register_pipe #(
        .WIDTH (DATA_W),
        .DEPTH (HALF)
    ) mul_pipe_i (
        .clk   (clk),
        .i_rst (i_rst),
        .i_d   (prod),
        .o_q   (mul_h)
    );

    // operands and side band delayed to line up with mul_h
    register_pipe #(
        .WIDTH (HALF_W),
        .DEPTH (HALF)
    ) half_pipe_i (
        .clk   (clk),
        .i_rst (i_rst),
        .i_d   ({s_in.last, s_in.valid, s_in.op, i_c, i_b, s_in.data}),
        .o_q   ({last_h, valid_h, op_h_raw, c_h, b_h, a_h})
    );

    assign op_h = pe_op_e'(op_h_raw);

    // ADD sums the raw operands, MACC the product and c
    // other ops ignore the sum
    always_comb begin
        if (op_h == OP_ADD) begin
            add_in = a_h + b_h;
        end else begin
            add_in = mul_h + c_h;   // wraps
        end
    end

    register_pipe #(
        .WIDTH (DATA_W),
        .DEPTH (HALF)
    ) add_pipe_i (
        .clk   (clk),
        .i_rst (i_rst),
        .i_d   (add_in),
        .o_q   (sum_f)
    );

    // MUL result waits out the add stage
    register_pipe #(
        .WIDTH (DATA_W),
        .DEPTH (HALF)
    ) mul_dly_pipe_i (
        .clk   (clk),
        .i_rst (i_rst),
        .i_d   (mul_h),
        .o_q   (mul_f)
    );

    // second half of the side band, chained from the first
    register_pipe #(
        .WIDTH (FULL_W),
        .DEPTH (HALF)
    ) full_pipe_i (
        .clk   (clk),
        .i_rst (i_rst),
        .i_d   ({last_h, valid_h, op_h_raw, a_h}),
        .o_q   ({last_f, valid_f, op_f_raw, a_f})
    );

    assign op_f = pe_op_e'(op_f_raw);

    // result select by the op that came with this beat
    always_comb begin
        case (op_f)
            OP_ADD, OP_MACC: m_out.data = sum_f;
            OP_MUL:          m_out.data = mul_f;
            default:         m_out.data = a_f;   // ACC, NOP and unused codes
        endcase
    end

    assign m_out.valid = valid_f;
    assign m_out.last  = last_f;
    assign m_out.op    = op_f;

endmodule

// ==== rtl/pe_ctrl.sv ====
`timescale 1ns/10ps

// axi4-lite register slave plus idle/run/drain sequencing
// every access answers OKAY, so no resp outputs
module pe_ctrl
    import pe_pkg::*;
#(
    parameter int LATENCY = 8
) (
    input  logic      clk,
    input  logic      i_rst,
    // write address and data
    input  axi_addr_t i_awaddr,
    input  logic      i_awvalid,
    output logic      o_awready,
    input  axi_data_t i_wdata,
    input  logic      i_wvalid,
    output logic      o_wready,
    // write response
    output logic      o_bvalid,
    input  logic      i_bready,
    // read address and data
    input  axi_addr_t i_araddr,
    input  logic      i_arvalid,
    output logic      o_arready,
    output axi_data_t o_rdata,
    output logic      o_rvalid,
    input  logic      i_rready,
    // to datapath
    output pe_op_e    o_op,        // op latched at start
    output len_t      o_len,       // length latched at start
    output logic      o_clear,
    output logic      o_in_ready,
    input  logic      i_in_valid,
    output logic      o_count_en,
    input  logic      i_last_elem
);

    localparam int DRAIN_W = $clog2(LATENCY);

    ctrl_state_e         state_q;
    logic [DRAIN_W-1:0]  drain_q;     // cycles spent in S_DRAIN
    logic                done_q;      // sticky until the next start
    logic                busy;
    pe_op_e              op_q;        // host copy of REG_OP
    len_t                len_q;       // host copy of REG_LEN
    logic                wr_en;
    logic                wr_fire;
    logic                rd_en;
    logic                rd_fire;
    logic                start_acc;   // start accepted this cycle

    // both valids in and no response outstanding
    assign wr_en   = i_awvalid && i_wvalid && !o_bvalid && !o_awready;
    assign wr_fire = o_awready && i_awvalid && o_wready && i_wvalid;
    assign rd_en   = i_arvalid && !o_arready && !o_rvalid;
    assign rd_fire = o_arready && i_arvalid;

    assign busy = (state_q != S_IDLE);

    // start while busy falls on the floor
    assign start_acc = wr_fire && (i_awaddr == REG_CTRL) && i_wdata[0] && !busy;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_awready <= 1'b0;
            o_wready  <= 1'b0;
            o_bvalid  <= 1'b0;
            o_arready <= 1'b0;
            o_rvalid  <= 1'b0;
        end else begin
            o_awready <= wr_en;   // one cycle pulse, both together
            o_wready  <= wr_en;
            o_arready <= rd_en;
            if (wr_fire) begin
                o_bvalid <= 1'b1;
            end else if (i_bready) begin
                o_bvalid <= 1'b0;   // held until taken
            end
            if (rd_fire) begin
                o_rvalid <= 1'b1;
            end else if (i_rready) begin
                o_rvalid <= 1'b0;
            end
        end
    end

    // host visible config
    always_ff @(posedge clk) begin
        if (i_rst) begin
            op_q  <= OP_ADD;
            len_q <= '0;
        end else if (wr_fire) begin
            case (i_awaddr)
                REG_OP:  op_q  <= pe_op_e'(i_wdata[2:0]);
                REG_LEN: len_q <= i_wdata[15:0];
                default: ;   // ctrl handled by start_acc, stat read only
            endcase
        end
    end

    // read data captured on the address handshake
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            case (i_araddr)
                REG_OP:   o_rdata <= axi_data_t'(op_q);
                REG_LEN:  o_rdata <= axi_data_t'(len_q);
                REG_STAT: o_rdata <= axi_data_t'({done_q, busy});
                default:  o_rdata <= '0;   // start reads back as zero
            endcase
        end
    end

    // sequencing
    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q <= S_IDLE;
            drain_q <= '0;
            done_q  <= 1'b0;
            o_op    <= OP_ADD;
            o_len   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (start_acc) begin
                        o_op  <= op_q;
                        o_len <= len_q;
                        if (len_q == '0) begin
                            done_q <= 1'b1;   // empty vector, done at once
                        end else begin
                            done_q  <= 1'b0;
                            state_q <= S_RUN;
                        end
                    end
                end
                S_RUN: begin
                    if (i_last_elem) begin
                        drain_q <= '0;
                        state_q <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    // final result leaves on the last drain cycle
                    if (drain_q == DRAIN_W'(LATENCY - 1)) begin
                        done_q  <= 1'b1;
                        state_q <= S_IDLE;
                    end else begin
                        drain_q <= drain_q + DRAIN_W'(1);
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    assign o_clear    = start_acc;   // counter back to zero at start
    assign o_in_ready = (state_q == S_RUN);
    assign o_count_en = i_in_valid && o_in_ready;

endmodule

// ==== rtl/pe_pkg.sv ====
package pe_pkg;

    // operand and result width, results wrap modulo 2**DATA_W
    parameter int DATA_W = 32;

    typedef logic [DATA_W-1:0] data_t;   // one element
    typedef logic [15:0]       len_t;    // vector length, element index

    // op encoding as seen by the host in REG_OP
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,   // a + b
        OP_ACC  = 3'd1,   // passes a, no accumulator yet
        OP_MUL  = 3'd2,   // a * b, low half
        OP_MACC = 3'd3,   // a * b + c
        OP_NOP  = 3'd4    // passes a
    } pe_op_e;

    // axi4-lite bus types
    typedef logic [3:0]  axi_addr_t;
    typedef logic [31:0] axi_data_t;

    // register map, byte addresses
    localparam axi_addr_t REG_CTRL = 4'd0;   // bit 0 start, self clearing
    localparam axi_addr_t REG_OP   = 4'd4;   // bits 2:0 op
    localparam axi_addr_t REG_LEN  = 4'd8;   // bits 15:0 length
    localparam axi_addr_t REG_STAT = 4'd12;  // bit 0 busy, bit 1 done

    // status bit positions
    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;

    // control fsm
    typedef enum logic [1:0] {
        S_IDLE,    // waiting for start
        S_RUN,     // accepting elements
        S_DRAIN    // last element accepted, pipeline emptying
    } ctrl_state_e;

endpackage

// ==== rtl/pe_stream_if.sv ====
`timescale 1ns/10ps

// one stream beat, no ready on purpose
// the consumer side never stalls
interface pe_stream_if
    import pe_pkg::*;
();

    data_t  data;    // operand a on input, result on output
    logic   valid;   // beat present this cycle
    logic   last;    // final element of the vector
    pe_op_e op;      // op travelling with the beat

    // producer side
    modport source (
        output data, valid, last, op
    );

    // consumer side
    modport sink (
        input data, valid, last, op
    );

endinterface

// ==== rtl/pe_top.sv ====
`timescale 1ns/10ps

// streaming vector element, axi4-lite config plus three operand streams
module pe_top
    import pe_pkg::*;
#(
    parameter int LATENCY = 8   // even, 4 or more
) (
    input  logic      clk,
    input  logic      i_rst,
    // axi4-lite slave
    input  axi_addr_t i_awaddr,
    input  logic      i_awvalid,
    output logic      o_awready,
    input  axi_data_t i_wdata,
    input  logic      i_wvalid,
    output logic      o_wready,
    output logic      o_bvalid,
    input  logic      i_bready,
    input  axi_addr_t i_araddr,
    input  logic      i_arvalid,
    output logic      o_arready,
    output axi_data_t o_rdata,
    output logic      o_rvalid,
    input  logic      i_rready,
    // operand streams, one shared valid and ready
    input  data_t     i_a,
    input  data_t     i_b,
    input  data_t     i_c,
    input  logic      i_in_valid,
    output logic      o_in_ready,
    // result stream, no back-pressure
    output data_t     o_res,
    output logic      o_res_valid,
    output logic      o_res_last
);

    pe_op_e run_op;      // op of the running vector
    len_t   run_len;
    logic   clear;
    logic   count_en;    // element accepted
    logic   last_elem;

    pe_stream_if in_s ();    // accepted beat into the alu
    pe_stream_if res_s ();   // result beat out of the alu

    pe_ctrl #(
        .LATENCY (LATENCY)
    ) ctrl_i (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_awaddr    (i_awaddr),
        .i_awvalid   (i_awvalid),
        .o_awready   (o_awready),
        .i_wdata     (i_wdata),
        .i_wvalid    (i_wvalid),
        .o_wready    (o_wready),
        .o_bvalid    (o_bvalid),
        .i_bready    (i_bready),
        .i_araddr    (i_araddr),
        .i_arvalid   (i_arvalid),
        .o_arready   (o_arready),
        .o_rdata     (o_rdata),
        .o_rvalid    (o_rvalid),
        .i_rready    (i_rready),
        .o_op        (run_op),
        .o_len       (run_len),
        .o_clear     (clear),
        .o_in_ready  (o_in_ready),
        .i_in_valid  (i_in_valid),
        .o_count_en  (count_en),
        .i_last_elem (last_elem)
    );

    elem_counter counter_i (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_clear     (clear),
        .i_count_en  (count_en),
        .i_len       (run_len),
        .o_count     (),           // debug probe point only
        .o_last_elem (last_elem)
    );

    // beat assembly, valid only on acceptance
    assign in_s.data  = i_a;
    assign in_s.valid = count_en;
    assign in_s.last  = last_elem;
    assign in_s.op    = run_op;

    pe_alu #(
        .LATENCY (LATENCY)
    ) alu_i (
        .clk   (clk),
        .i_rst (i_rst),
        .s_in  (in_s.sink),
        .i_b   (i_b),
        .i_c   (i_c),
        .m_out (res_s.source)
    );

    assign o_res       = res_s.data;
    assign o_res_valid = res_s.valid;
    assign o_res_last  = res_s.last;   // op of the result stays internal

endmodule

// ==== rtl/register_pipe.sv ====
`timescale 1ns/10ps

// shift chain of DEPTH registers, output DEPTH cycles after input
// DEPTH of one or more
module register_pipe #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  logic             clk,
    input  logic             i_rst,
    input  logic [WIDTH-1:0] i_d,
    output logic [WIDTH-1:0] o_q
);

    logic [WIDTH-1:0] stage_q [DEPTH];   // stage 0 nearest the input

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;   // whole chain zero, valids included
            end
        end else begin
            stage_q[0] <= i_d;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];   // advance one stage
            end
        end
    end

    assign o_q = stage_q[DEPTH-1];   // oldest entry

endmodule

// ==== tb/pe_stim.txt ====
// header line: op len (hex), then len element lines: a b c expected (hex)
// op ffffffff ends the file
// add, wraparound included
0 4
ffffffff 00000001 00000000 00000000
7fffffff 00000001 00000000 80000000
00000010 00000020 00000000 00000030
12345678 87654321 00000000 99999999
// mul, low half of the product
2 4
00000003 00000005 00000000 0000000f
ffffffff ffffffff 00000000 00000001
00010000 00010000 00000000 00000000
00012345 00000010 00000000 00123450
// macc
3 3
00000002 00000003 00000004 0000000a
ffffffff 00000002 00000003 00000001
00010000 00010000 00000005 00000005
// acc, a passes through
1 2
deadbeef 11111111 22222222 deadbeef
00000001 ffffffff ffffffff 00000001
// nop, a passes through
4 3
cafef00d 00000007 00000009 cafef00d
00000000 12345678 9abcdef0 00000000
80000000 80000000 80000000 80000000
// empty vector, done at once
0 0
// end marker
ffffffff 0

// ==== tb/tb_pe_top.sv ====
`timescale 1ns/10ps

// drives each vector of tb/pe_stim.txt through axi4-lite config and the operand stream
module tb_pe_top
    import pe_pkg::*;
();

    localparam int LATENCY = 8;
    localparam int TMO     = 200;   // cycles allowed per wait
    localparam int MEM_D   = 256;

    logic      clk;
    logic      i_rst;
    axi_addr_t i_awaddr;
    logic      i_awvalid;
    logic      o_awready;
    axi_data_t i_wdata;
    logic      i_wvalid;
    logic      o_wready;
    logic      o_bvalid;
    logic      i_bready;
    axi_addr_t i_araddr;
    logic      i_arvalid;
    logic      o_arready;
    axi_data_t o_rdata;
    logic      o_rvalid;
    logic      i_rready;
    data_t     i_a;
    data_t     i_b;
    data_t     i_c;
    logic      i_in_valid;
    logic      o_in_ready;
    data_t     o_res;
    logic      o_res_valid;
    logic      o_res_last;

    logic [31:0] stim_mem [0:MEM_D-1];   // headers and element lines in one flat array
    data_t       exp_data_q [$];         // one entry per accepted element
    logic        exp_last_q [$];
    int          acc_cyc_q [$];          // edge index of acceptance
    string       test_name;
    int          cyc;                    // rising edges so far
    int          rcv_cnt;                // results of the current vector
    int          chk_cnt;
    int          err_cnt;                // value mismatches
    int          fault_cnt;              // timeouts and protocol faults
    logic        hung;

    pe_top #(
        .LATENCY (LATENCY)
    ) dut_i (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_awaddr    (i_awaddr),
        .i_awvalid   (i_awvalid),
        .o_awready   (o_awready),
        .i_wdata     (i_wdata),
        .i_wvalid    (i_wvalid),
        .o_wready    (o_wready),
        .o_bvalid    (o_bvalid),
        .i_bready    (i_bready),
        .i_araddr    (i_araddr),
        .i_arvalid   (i_arvalid),
        .o_arready   (o_arready),
        .o_rdata     (o_rdata),
        .o_rvalid    (o_rvalid),
        .i_rready    (i_rready),
        .i_a         (i_a),
        .i_b         (i_b),
        .i_c         (i_c),
        .i_in_valid  (i_in_valid),
        .o_in_ready  (o_in_ready),
        .o_res       (o_res),
        .o_res_valid (o_res_valid),
        .o_res_last  (o_res_last)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_data(input string name, input data_t exp, input data_t act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s last: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input axi_data_t exp, input axi_data_t act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        chk_cnt++;
        if (act != exp) begin
            err_cnt++;
            $display("ERR %s latency: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic flag_timeout(input string what);
        fault_cnt++;
        hung = 1'b1;   // later steps skip themselves
        $display("timeout in %s: %s", test_name, what);
    endtask

    task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
        int n;
        if (!hung) begin
            @(posedge clk);
            i_awaddr  <= addr;
            i_awvalid <= 1'b1;
            i_wdata   <= data;
            i_wvalid  <= 1'b1;
            i_bready  <= 1'b1;
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!o_awready && !o_wready && n < TMO);
            if (!o_awready && !o_wready) begin
                flag_timeout("write address and data never taken");
            end else if (o_awready !== o_wready) begin
                fault_cnt++;
                $display("failure in %s: awready and wready not raised together", test_name);
            end
            @(posedge clk);   // handshake edge
            i_awvalid <= 1'b0;
            i_wvalid  <= 1'b0;
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!o_bvalid && n < TMO);
            if (!o_bvalid) flag_timeout("write response never came");
            @(posedge clk);   // response taken here
            i_bready <= 1'b0;
        end
    endtask

    task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
        int n;
        data = '0;
        if (!hung) begin
            @(posedge clk);
            i_araddr  <= addr;
            i_arvalid <= 1'b1;
            i_rready  <= 1'b1;
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!o_arready && n < TMO);
            if (!o_arready) flag_timeout("read address never taken");
            @(posedge clk);
            i_arvalid <= 1'b0;
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!o_rvalid && n < TMO);
            if (!o_rvalid) flag_timeout("read data never came");
            data = o_rdata;   // sampled mid cycle
            @(posedge clk);
            i_rready <= 1'b0;
        end
    endtask

    // one element per loop with random idle cycles between them
    task automatic drive_vector(input int base, input int len);
        int n;
        int idx;
        for (int e = 0; e < len && !hung; e++) begin
            idx = base + 4 * e;
            if ($urandom % 4 == 0) begin
                i_in_valid <= 1'b0;   // gap
                @(posedge clk);
            end
            i_a        <= data_t'(stim_mem[idx]);
            i_b        <= data_t'(stim_mem[idx + 1]);
            i_c        <= data_t'(stim_mem[idx + 2]);
            i_in_valid <= 1'b1;
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!o_in_ready && n < TMO);
            if (!o_in_ready) begin
                flag_timeout("input stream never ready");
            end else begin
                exp_data_q.push_back(data_t'(stim_mem[idx + 3]));
                exp_last_q.push_back(e == len - 1);
                acc_cyc_q.push_back(cyc + 1);   // accepted on the coming edge
            end
            @(posedge clk);
        end
        i_in_valid <= 1'b0;
    endtask

    // result monitor pairs each result with the oldest accepted element
    initial begin
        forever begin
            @(negedge clk);
            if (o_res_valid) begin
                if (exp_data_q.size() == 0) begin
                    fault_cnt++;
                    $display("failure in %s: result with no accepted element", test_name);
                end else begin
                    check_data(test_name, exp_data_q.pop_front(), o_res);
                    check_last(test_name, exp_last_q.pop_front(), o_res_last);
                    check_latency(test_name, LATENCY, cyc + 1 - acc_cyc_q.pop_front());
                end
                rcv_cnt++;
            end else if (o_res_last) begin
                fault_cnt++;
                $display("failure in %s: last flag high without a result", test_name);
            end
        end
    end

    initial begin
        int          p;
        int          len;
        int          n;
        logic [31:0] op_w;
        axi_data_t   rd;
        int unsigned seed;
        seed       = $urandom(32'hf6e);
        cyc        = 0;
        rcv_cnt    = 0;
        chk_cnt    = 0;
        err_cnt    = 0;
        fault_cnt  = 0;
        hung       = 1'b0;
        test_name  = "reset";
        i_rst      = 1'b1;
        i_awaddr   = '0;
        i_awvalid  = 1'b0;
        i_wdata    = '0;
        i_wvalid   = 1'b0;
        i_bready   = 1'b0;
        i_araddr   = '0;
        i_arvalid  = 1'b0;
        i_rready   = 1'b0;
        i_a        = '0;
        i_b        = '0;
        i_c        = '0;
        i_in_valid = 1'b0;
        $readmemh("tb/pe_stim.txt", stim_mem);
        repeat (4) @(posedge clk);
        i_rst <= 1'b0;
        @(posedge clk);
        if ($isunknown(stim_mem[0])) begin
            fault_cnt++;
            $display("stimulus file tb/pe_stim.txt is missing or empty");
        end
        p = 0;
        while (!hung && p < MEM_D - 1 && !$isunknown(stim_mem[p])
               && stim_mem[p] != 32'hffffffff) begin
            op_w      = stim_mem[p];
            len       = int'(stim_mem[p + 1]);
            test_name = $sformatf("vec_%0d_op%0d_len%0d", p, op_w, len);
            if (p + 2 + 4 * len > MEM_D) begin
                fault_cnt++;
                $display("vector %s runs past the end of the stimulus memory", test_name);
                break;
            end
            axi_write(REG_OP, op_w);
            axi_write(REG_LEN, axi_data_t'(len));
            axi_read(REG_OP, rd);
            check_reg({test_name, " op readback"}, op_w, rd);
            axi_read(REG_LEN, rd);
            check_reg({test_name, " len readback"}, axi_data_t'(len), rd);
            rcv_cnt = 0;
            axi_write(REG_CTRL, 32'h1);
            if (len > 0) begin
                fork
                    drive_vector(p + 2, len);
                    begin
                        repeat (2) @(posedge clk);
                        axi_write(REG_CTRL, 32'h1);   // second start while busy is ignored
                    end
                join
                n = 0;
                while (!hung && rcv_cnt < len && n < TMO) begin
                    @(negedge clk);
                    n++;
                end
                if (rcv_cnt < len) flag_timeout("results missing");
            end
            axi_read(REG_STAT, rd);
            check_reg({test_name, " status"}, axi_data_t'(1 << STAT_DONE), rd);   // done only
            p = p + 2 + 4 * len;
        end
        if (exp_data_q.size() != 0) begin
            fault_cnt++;
            $display("%0d accepted elements never produced a result", exp_data_q.size());
        end
        $display("checks %0d, mismatches %0d, other failures %0d", chk_cnt, err_cnt, fault_cnt);
        if (err_cnt == 0 && fault_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
